/* Makefile */
VERILATOR ?= verilator
TOP ?= tbPortal
BUILD_DIR ?= build
FLAGS ?= --binary --timing --assert --timescale 1ns/100ps

SRCS := $(shell grep -v '^+' tb.f)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): tb.f $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f tb.f

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

/* dv/axiPortal_asserts.sv */
`timescale 1ns/100ps

module axiPortal_asserts (
  input logic CLK,
  input logic nRST,
  input logic rValid,
  input logic rReady,
  input portalPkg::rDataT r,
  input logic bValid,
  input logic bReady,
  input logic [portalPkg::ID_W-1:0] bId,
  input logic interrupt,
  input logic grantValid,
  input portalPkg::beatKindT grantKind,
  input portalPkg::beatT grantBeat
);

  logic lastWrite;  // final write beat granted
  int failCount = 0;  // assertions fired so far

  assign lastWrite = grantValid && (grantKind == portalPkg::BEAT_WRITE) && grantBeat.last;

  rHold: assert property (@(posedge CLK) disable iff (!nRST)
    rValid && !rReady |=> rValid && $stable(r))
    else begin
      failCount++;
      $error("R payload changed while waiting for rReady");
    end

  bHold: assert property (@(posedge CLK) disable iff (!nRST)
    bValid && !bReady |=> bValid && $stable(bId))
    else begin
      failCount++;
      $error("B response changed while waiting for bReady");
    end

  // a fresh B needs a last write beat one cycle before
  bCause: assert property (@(posedge CLK) disable iff (!nRST)
    bValid && !($past(bValid) && !$past(bReady)) |-> $past(lastWrite))
    else begin
      failCount++;
      $error("B response without a completed last write beat");
    end

  resetInt: assert property (@(posedge CLK) !nRST |=> !interrupt)
    else begin
      failCount++;
      $error("interrupt high during reset");
    end

endmodule

bind axiPortal axiPortal_asserts chk (.*);

/* dv/tbPortal.sv */
`timescale 1ns/100ps

module tbPortal;

  typedef logic [portalPkg::ADDR_W-1:0] addrT;
  typedef logic [portalPkg::ID_W-1:0] idT;
  typedef logic [portalPkg::LEN_W-1:0] lenT;
  typedef logic [portalPkg::DATA_W-1:0] wordT;

  localparam int PERIOD = 8;
  localparam int BUDGET = 5 + 40 + 30 + 60 + 50 + 80 + 70;  // cycles per test, summed
  localparam addrT CTRL = 13'h0000;
  localparam addrT CTRL_EN = 13'h0004;
  localparam addrT IND_CTRL_ID = 13'h1010;
  localparam addrT REQ_DATA = 13'h0020;  // bit 5 leaves the control page
  localparam addrT REQ_STAT = 13'h0024;
  localparam addrT REQ_SPARE = 13'h0028;  // offsets 08..14 touch nothing
  localparam addrT IND_DATA = 13'h1020;
  localparam addrT IND_STAT = 13'h1024;

  logic CLK = 1'b0;
  logic nRST;
  logic awValid;
  logic awReady;
  portalPkg::axiAddrT aw;
  logic wValid;
  logic wReady;
  wordT wData;
  logic wLast;
  logic bValid;
  logic bReady;
  idT bId;
  logic arValid;
  logic arReady;
  portalPkg::axiAddrT ar;
  logic rValid;
  logic rReady;
  portalPkg::rDataT r;
  logic interrupt;

  logic bpMode;  // random rReady while collecting
  wordT wrData [16];
  wordT rdData [16];
  idT rdId [16];
  logic rdLast [16];
  idT gotB;
  int firstLat;

  axiPortal uut (.*);

  always #(PERIOD / 2) CLK = ~CLK;

  initial begin
    #(BUDGET * 4 * PERIOD);
    $display("watchdog expired: the DUT stopped answering handshakes");
    $display("test failed");
    $fatal(1, "timeout");
  end

  initial begin
    wait (uut.chk.failCount != 0);
    $display("a bound assertion fired on the AXI channels");
    $display("test failed");
    $fatal(1, "assertion failure");
  end

  task automatic idle(input int n);
    repeat (n) @(posedge CLK);
  endtask

  task automatic checkValue(input wordT got, input wordT exp, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // expected control page word for a byte offset
  function automatic wordT ctrlWord(input int ofs, input logic ind, input logic pending,
                                    input logic en);
    case (ofs)
      'h00, 'h0C: return wordT'(pending);
      'h04: return wordT'(en);
      'h08: return 32'd1;
      'h10: return ind ? wordT'(portalPkg::PORTAL_IND_ID) : wordT'(portalPkg::PORTAL_REQ_ID);
      'h14: return wordT'(portalPkg::PORTAL_COUNT);
      default: return '0;
    endcase
  endfunction

  task automatic issueRead(input addrT start, input idT id, input int beats);
    ar <= '{addr: start, id: id, len: lenT'(beats - 1)};
    arValid <= 1'b1;
    @(posedge CLK);
    while (!arReady) @(posedge CLK);
    arValid <= 1'b0;
  endtask

  task automatic collectRead(input int beats);
    int n;
    int cyc;
    n = 0;
    cyc = 0;
    rReady <= bpMode ? 1'($urandom) : 1'b1;
    while (n < beats) begin
      @(posedge CLK);
      cyc++;
      if (rValid && rReady) begin
        if (n == 0) begin
          firstLat = cyc;
        end
        rdData[n] = r.data;
        rdId[n] = r.id;
        rdLast[n] = r.last;
        n++;
      end
      rReady <= bpMode ? 1'($urandom) : 1'b1;
    end
    rReady <= 1'b0;
  endtask

  task automatic axiRead(input addrT start, input idT id, input int beats);
    issueRead(start, id, beats);
    collectRead(beats);
  endtask

  task automatic axiWrite(input addrT start, input idT id, input int beats);
    aw <= '{addr: start, id: id, len: lenT'(beats - 1)};
    awValid <= 1'b1;
    @(posedge CLK);
    while (!awReady) @(posedge CLK);
    awValid <= 1'b0;
    for (int i = 0; i < beats; i++) begin
      wData <= wrData[i];
      wLast <= (i == beats - 1);
      wValid <= 1'b1;
      @(posedge CLK);
      while (!wReady) @(posedge CLK);
    end
    wValid <= 1'b0;
    wLast <= 1'b0;
    bReady <= 1'b1;
    @(posedge CLK);
    while (!bValid) @(posedge CLK);
    gotB = bId;
    bReady <= 1'b0;
  endtask

  task automatic checkControlBurst(input idT id);
    for (int i = 0; i < 6; i++) begin
      checkValue(rdData[i], ctrlWord(4 * i, 1'b0, 1'b0, 1'b0), $sformatf("ctrl word %0d", i));
      checkValue(32'(rdId[i]), 32'(id), $sformatf("R id on beat %0d", i));
      checkValue(32'(rdLast[i]), 32'(i == 5), $sformatf("R last on beat %0d", i));
    end
  endtask

  task automatic testControlPage();
    checkValue(32'(interrupt), 32'd0, "interrupt after reset");
    checkValue(32'(bValid), 32'd0, "bValid after reset");
    checkValue(32'(rValid), 32'd0, "rValid after reset");
    checkValue(32'(arReady), 32'd1, "arReady after reset");
    checkValue(32'(awReady), 32'd1, "awReady after reset");
    axiRead(CTRL, 6'h11, 6);
    checkValue(32'(firstLat), 32'd2, "first R beat latency");
    checkControlBurst(6'h11);
    axiRead(IND_CTRL_ID, 6'h12, 1);
    checkValue(rdData[0], ctrlWord('h10, 1'b1, 1'b0, 1'b0), "indication portal id");
  endtask

  task automatic testEchoSingle();
    idT id;
    id = idT'($urandom);
    wrData[0] = $urandom;
    axiWrite(REQ_DATA, id, 1);
    checkValue(32'(gotB), 32'(id), "B id");
    axiRead(IND_STAT, 6'h21, 1);
    checkValue(rdData[0], 32'd1, "queue count after one push");
    axiRead(IND_DATA, 6'h22, 1);
    checkValue(rdData[0], wrData[0], "echoed word");
    axiRead(IND_DATA, 6'h23, 1);
    checkValue(rdData[0], 32'd0, "read from empty queue");
  endtask

  task automatic testFillAndDrain();
    wordT sent [portalPkg::ECHO_DEPTH + 1];
    for (int i = 0; i <= portalPkg::ECHO_DEPTH; i++) begin
      if (i == portalPkg::ECHO_DEPTH) begin
        axiRead(REQ_STAT, 6'h24, 1);
        checkValue(rdData[0], 32'd0, "request status with full queue");
      end
      sent[i] = $urandom;
      wrData[0] = sent[i];
      axiWrite(REQ_DATA, idT'(i), 1);
    end
    for (int i = 0; i < portalPkg::ECHO_DEPTH; i++) begin
      axiRead(IND_DATA, idT'(i), 1);
      checkValue(rdData[0], sent[i], $sformatf("drained word %0d", i));
    end
    axiRead(IND_DATA, 6'h25, 1);
    checkValue(rdData[0], 32'd0, "overflow word was dropped");
  endtask

  task automatic testInterrupt();
    wrData[0] = 32'd1;
    axiWrite(CTRL_EN, 6'h31, 1);
    idle(1);
    checkValue(32'(interrupt), 32'd0, "interrupt with empty queue");
    wrData[0] = $urandom;
    axiWrite(REQ_DATA, 6'h32, 1);
    idle(1);
    checkValue(32'(interrupt), 32'd1, "interrupt after push");
    axiRead(IND_DATA, 6'h33, 1);
    idle(1);
    checkValue(32'(interrupt), 32'd0, "interrupt after pop");
    axiWrite(REQ_DATA, 6'h34, 1);
    wrData[0] = 32'd0;
    axiWrite(CTRL_EN, 6'h35, 1);
    idle(1);
    checkValue(32'(interrupt), 32'd0, "interrupt after disable");
    axiRead(IND_DATA, 6'h36, 1);  // leave the queue empty
  endtask

  task automatic testBackPressure();
    idT rid;
    idT wid;
    rid = idT'($urandom);
    wid = idT'($urandom);
    for (int i = 0; i < 4; i++) begin
      wrData[i] = $urandom;
    end
    bpMode = 1'b1;
    fork
      axiWrite(REQ_SPARE, wid, 4);
      axiRead(CTRL, rid, 6);
    join
    bpMode = 1'b0;
    checkControlBurst(rid);
    checkValue(32'(gotB), 32'(wid), "B id under back-pressure");
  endtask

  task automatic testResetMidBurst();
    wrData[0] = 32'd1;
    axiWrite(CTRL_EN, 6'h38, 1);
    wrData[0] = $urandom;
    axiWrite(REQ_DATA, 6'h39, 1);
    issueRead(CTRL, 6'h3A, 8);
    idle(4);  // rReady low, beats stall
    checkValue(32'(rValid), 32'd1, "R waiting before reset");
    checkValue(32'(arReady), 32'd0, "arReady during a stalled burst");
    nRST <= 1'b0;
    idle(2);
    nRST <= 1'b1;
    idle(1);
    testControlPage();
  endtask

  initial begin
    void'($urandom(32'h3565));
    nRST = 1'b0;
    awValid = 1'b0;
    aw = '0;
    wValid = 1'b0;
    wData = '0;
    wLast = 1'b0;
    bReady = 1'b0;
    arValid = 1'b0;
    ar = '0;
    rReady = 1'b0;
    bpMode = 1'b0;
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);
    testControlPage();
    testEchoSingle();
    testFillAndDrain();
    testInterrupt();
    testBackPressure();
    testResetMidBurst();
    if (uut.chk.failCount != 0) begin
      $display("%0d bound assertion checks fired", uut.chk.failCount);
      $display("test failed");
      $fatal(1, "assertion failure");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

/* src/axiPortal.sv */
`timescale 1ns/100ps

module axiPortal (
  input  logic CLK,
  input  logic nRST,
  input  logic awValid,
  output logic awReady,
  input  portalPkg::axiAddrT aw,
  input  logic wValid,
  output logic wReady,
  input  logic [portalPkg::DATA_W-1:0] wData,
  input  logic wLast,  // beat count comes from AW
  output logic bValid,
  input  logic bReady,
  output logic [portalPkg::ID_W-1:0] bId,
  input  logic arValid,
  output logic arReady,
  input  portalPkg::axiAddrT ar,
  output logic rValid,
  input  logic rReady,
  output portalPkg::rDataT r,
  output logic interrupt
);

  logic arBeatValid;
  logic arBeatReady;
  portalPkg::beatT arBeat;
  logic awBeatValid;
  logic awBeatReady;
  portalPkg::beatT awBeat;

  logic grantValid;
  portalPkg::beatKindT grantKind;
  portalPkg::beatT grantBeat;
  logic [portalPkg::DATA_W-1:0] grantData;
  logic readSlotFree;
  logic writeSlotFree;

  logic pushValid;
  logic [portalPkg::DATA_W-1:0] pushData;
  logic popReq;
  logic [portalPkg::DATA_W-1:0] headData;
  logic notEmpty;
  logic notFull;
  logic [portalPkg::CNT_W-1:0] count;

  burstSequencer arSeq (
    .CLK(CLK), .nRST(nRST),
    .reqValid(arValid), .reqReady(arReady), .req(ar),
    .beatValid(arBeatValid), .beatReady(arBeatReady), .beat(arBeat)
  );

  burstSequencer awSeq (
    .CLK(CLK), .nRST(nRST),
    .reqValid(awValid), .reqReady(awReady), .req(aw),
    .beatValid(awBeatValid), .beatReady(awBeatReady), .beat(awBeat)
  );

  beatArbiter arb (
    .CLK(CLK), .nRST(nRST),
    .rdValid(arBeatValid), .rdReady(arBeatReady), .rdBeat(arBeat),
    .wrValid(awBeatValid), .wrReady(awBeatReady), .wrBeat(awBeat),
    .wValid(wValid), .wReady(wReady), .wData(wData),
    .readSlotFree(readSlotFree), .writeSlotFree(writeSlotFree),
    .grantValid(grantValid), .grantKind(grantKind),
    .grantBeat(grantBeat), .grantData(grantData)
  );

  portalRegs regs (
    .CLK(CLK), .nRST(nRST),
    .grantValid(grantValid), .grantKind(grantKind),
    .grantBeat(grantBeat), .grantData(grantData),
    .readSlotFree(readSlotFree), .writeSlotFree(writeSlotFree),
    .rValid(rValid), .rReady(rReady), .r(r),
    .bValid(bValid), .bReady(bReady), .bId(bId),
    .pushValid(pushValid), .pushData(pushData), .popReq(popReq),
    .headData(headData), .notEmpty(notEmpty), .notFull(notFull), .count(count),
    .interrupt(interrupt)
  );

  echoQueue queue (
    .CLK(CLK), .nRST(nRST),
    .pushValid(pushValid), .pushData(pushData), .notFull(notFull),
    .popReq(popReq), .headData(headData), .notEmpty(notEmpty), .count(count)
  );

endmodule

/* src/beatArbiter.sv */
`timescale 1ns/100ps

module beatArbiter (
  input  logic CLK,
  input  logic nRST,
  input  logic rdValid,
  output logic rdReady,
  input  portalPkg::beatT rdBeat,
  input  logic wrValid,
  output logic wrReady,
  input  portalPkg::beatT wrBeat,
  input  logic wValid,
  output logic wReady,
  input  logic [portalPkg::DATA_W-1:0] wData,
  input  logic readSlotFree,
  input  logic writeSlotFree,
  output logic grantValid,
  output portalPkg::beatKindT grantKind,
  output portalPkg::beatT grantBeat,
  output logic [portalPkg::DATA_W-1:0] grantData
);

  portalPkg::beatKindT lastKind;  // kind granted most recently

  logic rdOk;
  logic wrOk;
  logic pickWrite;

  assign rdOk = rdValid && readSlotFree;
  // a last write beat needs room for its B response
  assign wrOk = wrValid && wValid && (!wrBeat.last || writeSlotFree);
  assign pickWrite = wrOk && (!rdOk || lastKind == portalPkg::BEAT_READ);

  assign grantValid = rdOk || wrOk;
  assign grantKind = pickWrite ? portalPkg::BEAT_WRITE : portalPkg::BEAT_READ;
  assign grantBeat = pickWrite ? wrBeat : rdBeat;
  assign grantData = pickWrite ? wData : '0;

  assign rdReady = rdOk && !pickWrite;
  assign wrReady = pickWrite;  // beat and W word go together
  assign wReady = pickWrite;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      lastKind <= portalPkg::BEAT_WRITE;  // reads first after reset
    end else if (grantValid) begin
      lastKind <= grantKind;
    end
  end

endmodule

/* src/burstSequencer.sv */
`timescale 1ns/100ps

module burstSequencer (
  input  logic CLK,
  input  logic nRST,
  input  logic reqValid,
  output logic reqReady,
  input  portalPkg::axiAddrT req,
  output logic beatValid,
  input  logic beatReady,
  output portalPkg::beatT beat
);

  typedef logic [portalPkg::LEN_W:0] remainT;  // up to 16 beats

  portalPkg::seqStateT state;
  portalPkg::beatT cur;
  remainT remain;  // beats left including the current one

  logic reqTake;
  logic beatTake;

  assign reqReady = (state == portalPkg::SEQ_IDLE);
  assign beatValid = (state == portalPkg::SEQ_BURST);
  assign beat = cur;

  assign reqTake = reqValid && reqReady;
  assign beatTake = beatValid && beatReady;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      state <= portalPkg::SEQ_IDLE;
    end else begin
      case (state)
        portalPkg::SEQ_IDLE: begin
          if (reqTake) begin
            state <= portalPkg::SEQ_BURST;
          end
        end
        portalPkg::SEQ_BURST: begin
          if (beatTake && cur.last) begin
            state <= portalPkg::SEQ_IDLE;  // burst done
          end
        end
        default: state <= portalPkg::SEQ_IDLE;
      endcase
    end
  end

  // page selects decoded once per burst
  always_ff @(posedge CLK) begin
    if (reqTake) begin
      cur.offset <= req.addr[portalPkg::OFS_W-1:0];
      cur.ctrlPage <= (req.addr[portalPkg::ADDR_W-2:portalPkg::OFS_W] == '0);
      cur.indSel <= req.addr[portalPkg::ADDR_W-1];
      cur.id <= req.id;
      cur.last <= (req.len == '0);
      remain <= remainT'(req.len) + remainT'(1);
    end else if (beatTake) begin
      cur.offset <= cur.offset + portalPkg::OFS_STEP;
      cur.last <= (remain == remainT'(2));  // next one is the final beat
      remain <= remain - remainT'(1);
    end
  end

endmodule

/* src/echoQueue.sv */
`timescale 1ns/100ps

module echoQueue (
  input  logic CLK,
  input  logic nRST,
  input  logic pushValid,
  input  logic [portalPkg::DATA_W-1:0] pushData,
  output logic notFull,
  input  logic popReq,
  output logic [portalPkg::DATA_W-1:0] headData,
  output logic notEmpty,
  output logic [portalPkg::CNT_W-1:0] count
);

  typedef logic [portalPkg::PTR_W-1:0] ptrT;
  typedef logic [portalPkg::CNT_W-1:0] cntT;

  logic [portalPkg::DATA_W-1:0] mem [portalPkg::ECHO_DEPTH];
  ptrT wrPtr;
  ptrT rdPtr;
  logic doPush;
  logic doPop;

  assign notFull = (count != cntT'(portalPkg::ECHO_DEPTH));
  assign notEmpty = (count != '0);
  assign headData = mem[rdPtr];

  assign doPush = pushValid && notFull;  // extra words are dropped
  assign doPop = popReq && notEmpty;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == ptrT'(portalPkg::ECHO_DEPTH - 1)) ? '0 : wrPtr + ptrT'(1);
      end
      if (doPop) begin
        rdPtr <= (rdPtr == ptrT'(portalPkg::ECHO_DEPTH - 1)) ? '0 : rdPtr + ptrT'(1);
      end
      case ({doPush, doPop})
        2'b10: count <= count + cntT'(1);
        2'b01: count <= count - cntT'(1);
        default: count <= count;  // idle or both
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

endmodule

/* src/portalPkg.sv */
package portalPkg;

  localparam int ADDR_W = 13;  // bit 12 picks the indication side
  localparam int ID_W = 6;
  localparam int LEN_W = 4;
  localparam int DATA_W = 32;
  localparam int OFS_W = 5;  // byte offset inside a page

  localparam int ECHO_DEPTH = 4;
  localparam int PTR_W = $clog2(ECHO_DEPTH);
  localparam int CNT_W = $clog2(ECHO_DEPTH + 1);  // 0..ECHO_DEPTH

  localparam int PORTAL_REQ_ID = 5;
  localparam int PORTAL_IND_ID = 6;
  localparam int PORTAL_COUNT = 2;

  // control page
  localparam logic [OFS_W-1:0] OFS_INT_STATUS = 5'h00;
  localparam logic [OFS_W-1:0] OFS_INT_ENABLE = 5'h04;
  localparam logic [OFS_W-1:0] OFS_ONE = 5'h08;
  localparam logic [OFS_W-1:0] OFS_STATUS_COPY = 5'h0C;
  localparam logic [OFS_W-1:0] OFS_PORTAL_ID = 5'h10;
  localparam logic [OFS_W-1:0] OFS_PORTAL_COUNT = 5'h14;

  // request and indication portals
  localparam logic [OFS_W-1:0] OFS_DATA = 5'h00;
  localparam logic [OFS_W-1:0] OFS_STATUS = 5'h04;

  localparam logic [OFS_W-1:0] OFS_STEP = 5'h04;  // one word per beat

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0] id;
    logic [LEN_W-1:0] len;  // beats minus one
  } axiAddrT;

  typedef struct packed {
    logic [OFS_W-1:0] offset;
    logic ctrlPage;  // bits 11..5 all zero
    logic indSel;
    logic [ID_W-1:0] id;
    logic last;
  } beatT;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0] id;
    logic last;
  } rDataT;

  typedef enum logic {
    BEAT_READ,
    BEAT_WRITE
  } beatKindT;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_BURST
  } seqStateT;

endpackage

/* src/portalRegs.sv */
`timescale 1ns/100ps

module portalRegs (
  input  logic CLK,
  input  logic nRST,
  input  logic grantValid,
  input  portalPkg::beatKindT grantKind,
  input  portalPkg::beatT grantBeat,
  input  logic [portalPkg::DATA_W-1:0] grantData,
  output logic readSlotFree,
  output logic writeSlotFree,
  output logic rValid,
  input  logic rReady,
  output portalPkg::rDataT r,
  output logic bValid,
  input  logic bReady,
  output logic [portalPkg::ID_W-1:0] bId,
  output logic pushValid,
  output logic [portalPkg::DATA_W-1:0] pushData,
  output logic popReq,
  input  logic [portalPkg::DATA_W-1:0] headData,
  input  logic notEmpty,
  input  logic notFull,
  input  logic [portalPkg::CNT_W-1:0] count,
  output logic interrupt
);

  typedef logic [portalPkg::DATA_W-1:0] wordT;

  logic rdGrant;
  logic wrGrant;
  logic reqPage;
  logic intEnable;
  logic rdPop;
  wordT rdWord;

  assign rdGrant = grantValid && (grantKind == portalPkg::BEAT_READ);
  assign wrGrant = grantValid && (grantKind == portalPkg::BEAT_WRITE);
  assign reqPage = !grantBeat.ctrlPage && !grantBeat.indSel;

  assign readSlotFree = !rValid || rReady;  // R register empty or draining
  assign writeSlotFree = !bValid || bReady;

  always_comb begin
    rdWord = '0;
    rdPop = 1'b0;
    if (grantBeat.ctrlPage) begin
      case (grantBeat.offset)
        portalPkg::OFS_INT_STATUS: rdWord = wordT'(notEmpty);
        portalPkg::OFS_INT_ENABLE: rdWord = wordT'(intEnable);
        portalPkg::OFS_ONE: rdWord = wordT'(1);
        portalPkg::OFS_STATUS_COPY: rdWord = wordT'(notEmpty);
        portalPkg::OFS_PORTAL_ID: begin
          rdWord = grantBeat.indSel ? wordT'(portalPkg::PORTAL_IND_ID)
                                    : wordT'(portalPkg::PORTAL_REQ_ID);
        end
        portalPkg::OFS_PORTAL_COUNT: rdWord = wordT'(portalPkg::PORTAL_COUNT);
        default: rdWord = '0;
      endcase
    end else if (grantBeat.indSel) begin
      case (grantBeat.offset)
        portalPkg::OFS_DATA: begin
          rdWord = notEmpty ? headData : '0;  // empty queue reads zero
          rdPop = notEmpty;
        end
        portalPkg::OFS_STATUS: rdWord = wordT'(count);
        default: rdWord = '0;
      endcase
    end else if (grantBeat.offset == portalPkg::OFS_STATUS) begin
      rdWord = wordT'(notFull);  // request side has room
    end
  end

  assign popReq = rdGrant && rdPop;
  assign pushValid = wrGrant && reqPage && (grantBeat.offset == portalPkg::OFS_DATA) && notFull;
  assign pushData = grantData;

  assign interrupt = intEnable && notEmpty;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      rValid <= 1'b0;
      bValid <= 1'b0;
      intEnable <= 1'b0;
    end else begin
      if (rdGrant) begin
        rValid <= 1'b1;
      end else if (rReady) begin
        rValid <= 1'b0;
      end
      if (wrGrant && grantBeat.last) begin
        bValid <= 1'b1;
      end else if (bReady) begin
        bValid <= 1'b0;
      end
      if (wrGrant && grantBeat.ctrlPage && grantBeat.offset == portalPkg::OFS_INT_ENABLE) begin
        intEnable <= grantData[0];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rdGrant) begin
      r <= '{data: rdWord, id: grantBeat.id, last: grantBeat.last};
    end
    if (wrGrant && grantBeat.last) begin
      bId <= grantBeat.id;
    end
  end

endmodule

/* tb.f */
src/portalPkg.sv
src/burstSequencer.sv
src/beatArbiter.sv
src/portalRegs.sv
src/echoQueue.sv
src/axiPortal.sv
dv/axiPortal_asserts.sv
dv/tbPortal.sv
